/* hw/noc_settings.svh */
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Switch geometry
`define NOC_NUM_PORTS 4
`define NOC_NUM_VCS 2

// Flits per input FIFO and the initial credit per output VC
`define NOC_BUF_DEPTH 4

// Node addressing
`define NOC_NODE_BITS 5
`define NOC_TABLE_SIZE 32
`define NOC_NODE_ID 3

`endif

/* hw/noc_pkg.sv */
`include "noc_settings.svh"

package noc_pkg;

    typedef logic [`NOC_NODE_BITS-1:0] node_id_t;
    typedef logic [1:0] port_t;
    typedef logic vc_t;
    typedef logic [3:0] fmt_t;

    localparam fmt_t FMT_DATA = 4'h0;
    localparam fmt_t FMT_CFG = 4'h1;

    // One whole packet per 32-bit flit
    typedef struct packed {
        fmt_t fmt;
        node_id_t dest;
        vc_t vc;
        logic [21:0] payload;
    } flit_t;

    // Payload layout of a configuration flit
    typedef struct packed {
        logic [14:0] unused;
        node_id_t index;
        port_t port;
    } cfg_payload_t;

    // One bit per FIFO at index port + NUM_PORTS * vc
    typedef logic [`NOC_NUM_PORTS*`NOC_NUM_VCS-1:0] credit_t;

endpackage

/* hw/vc_buffers.sv */
`timescale 1ns/10ps

`include "noc_settings.svh"

module vc_buffers (
    input  logic clk,
    input  logic rst_n,
    input  logic [`NOC_NUM_PORTS-1:0] in_valid,
    input  noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] in_flit,
    input  noc_pkg::credit_t pop,
    output noc_pkg::credit_t head_valid,
    output noc_pkg::flit_t [`NOC_NUM_PORTS*`NOC_NUM_VCS-1:0] head_flit,
    output noc_pkg::credit_t credit_out
);
    import noc_pkg::*;

    localparam int NUM_FIFOS = `NOC_NUM_PORTS * `NOC_NUM_VCS;
    localparam int PTR_W = $clog2(`NOC_BUF_DEPTH);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`NOC_BUF_DEPTH - 1);
    localparam logic [PTR_W:0] DEPTH = (PTR_W + 1)'(`NOC_BUF_DEPTH);

    flit_t mem [NUM_FIFOS][`NOC_BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr [NUM_FIFOS];
    logic [PTR_W-1:0] rd_ptr [NUM_FIFOS];
    logic [PTR_W:0] count [NUM_FIFOS];

    credit_t push;
    credit_t full;
    credit_t wr_en;
    credit_t rd_en;

    for (genvar i = 0; i < NUM_FIFOS; i++) begin : g_fifo
        localparam int PORT = i % `NOC_NUM_PORTS;
        localparam int VC = i / `NOC_NUM_PORTS;

        // Steer the arriving flit by its vc field
        assign push[i] = in_valid[PORT] && (in_flit[PORT].vc == vc_t'(VC));
        assign full[i] = (count[i] == DEPTH);
        // Overflow is an upstream credit violation and the flit is dropped
        assign wr_en[i] = push[i] && !full[i];
        assign rd_en[i] = pop[i] && head_valid[i];

        assign head_valid[i] = (count[i] != '0);
        assign head_flit[i] = mem[i][rd_ptr[i]];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                count[i] <= '0;
            end else begin
                if (wr_en[i]) begin
                    wr_ptr[i] <= (wr_ptr[i] == LAST) ? '0 : wr_ptr[i] + 1'b1;
                end
                if (rd_en[i]) begin
                    rd_ptr[i] <= (rd_ptr[i] == LAST) ? '0 : rd_ptr[i] + 1'b1;
                end
                case ({wr_en[i], rd_en[i]})
                    2'b10: count[i] <= count[i] + 1'b1;
                    2'b01: count[i] <= count[i] - 1'b1;
                    default: count[i] <= count[i];
                endcase
            end
        end

        always_ff @(posedge clk) begin
            if (wr_en[i]) begin
                mem[i][wr_ptr[i]] <= in_flit[PORT];
            end
        end
    end

    // One credit back upstream per flit leaving a FIFO
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_out <= '0;
        end else begin
            credit_out <= rd_en;
        end
    end

endmodule

/* hw/route_compute.sv */
`timescale 1ns/10ps

`include "noc_settings.svh"

module route_compute #(
    parameter noc_pkg::node_id_t node = `NOC_NODE_ID
) (
    input  logic clk,
    input  logic rst_n,
    input  noc_pkg::credit_t head_valid,
    input  noc_pkg::flit_t [`NOC_NUM_PORTS*`NOC_NUM_VCS-1:0] head_flit,
    output noc_pkg::port_t [`NOC_NUM_PORTS*`NOC_NUM_VCS-1:0] head_port,
    output noc_pkg::credit_t cfg_pop
);
    import noc_pkg::*;

    localparam int NUM_FIFOS = `NOC_NUM_PORTS * `NOC_NUM_VCS;

    port_t route_tbl [`NOC_TABLE_SIZE];
    cfg_payload_t [NUM_FIFOS-1:0] cfg_req;

    for (genvar i = 0; i < NUM_FIFOS; i++) begin : g_head
        // Table lookup by destination
        assign head_port[i] = route_tbl[head_flit[i].dest];
        assign cfg_req[i] = cfg_payload_t'(head_flit[i].payload);

        // Config addressed to this node is claimed here and never forwarded
        assign cfg_pop[i] = head_valid[i] && (head_flit[i].fmt == FMT_CFG) &&
                            (head_flit[i].dest == node);
    end

    // Table update is visible to lookups from the next cycle on.
    // If several heads hit one entry together, the lowest FIFO wins.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int d = 0; d < `NOC_TABLE_SIZE; d++) begin
                route_tbl[d] <= port_t'(d % `NOC_NUM_PORTS);
            end
        end else begin
            for (int i = NUM_FIFOS - 1; i >= 0; i--) begin
                if (cfg_pop[i]) begin
                    route_tbl[cfg_req[i].index] <= cfg_req[i].port;
                end
            end
        end
    end

endmodule

/* hw/switch_allocator.sv */
`timescale 1ns/10ps

`include "noc_settings.svh"

module switch_allocator (
    input  logic clk,
    input  logic rst_n,
    input  noc_pkg::credit_t head_valid,
    input  noc_pkg::port_t [`NOC_NUM_PORTS*`NOC_NUM_VCS-1:0] head_port,
    input  noc_pkg::credit_t cfg_pop,
    input  noc_pkg::credit_t credit_in,
    output logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_PORTS*`NOC_NUM_VCS-1:0] grant
);
    import noc_pkg::*;

    localparam int NUM_FIFOS = `NOC_NUM_PORTS * `NOC_NUM_VCS;
    localparam int IDX_W = $clog2(NUM_FIFOS);
    localparam int CNT_W = $clog2(`NOC_BUF_DEPTH + 1);

    logic [CNT_W-1:0] credit_cnt [NUM_FIFOS];
    logic [IDX_W-1:0] rr_ptr [`NOC_NUM_PORTS];
    logic [IDX_W-1:0] win_idx [`NOC_NUM_PORTS];
    logic [`NOC_NUM_PORTS-1:0] win;
    credit_t sent;

    // Round robin per output starting at the pointer
    always_comb begin
        int idx;
        int cnt_idx;
        grant = '0;
        win = '0;
        sent = '0;
        for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
            win_idx[o] = '0;
            for (int k = 0; k < NUM_FIFOS; k++) begin
                idx = (int'(rr_ptr[o]) + k) % NUM_FIFOS;
                // Output VC equals the input VC of the FIFO
                cnt_idx = o + `NOC_NUM_PORTS * (idx / `NOC_NUM_PORTS);
                if (!win[o] && head_valid[idx] && !cfg_pop[idx] &&
                    (head_port[idx] == port_t'(o)) && (credit_cnt[cnt_idx] != '0)) begin
                    win[o] = 1'b1;
                    win_idx[o] = IDX_W'(idx);
                    grant[o][idx] = 1'b1;
                    sent[cnt_idx] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
                rr_ptr[o] <= '0;
            end
        end else begin
            for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
                if (win[o]) begin
                    rr_ptr[o] <= (win_idx[o] == IDX_W'(NUM_FIFOS - 1)) ? '0 : win_idx[o] + 1'b1;
                end
            end
        end
    end

    // Downstream credits per output VC
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < NUM_FIFOS; c++) begin
                credit_cnt[c] <= CNT_W'(`NOC_BUF_DEPTH);
            end
        end else begin
            for (int c = 0; c < NUM_FIFOS; c++) begin
                case ({sent[c], credit_in[c]})
                    2'b10: credit_cnt[c] <= credit_cnt[c] - 1'b1;
                    2'b01: credit_cnt[c] <= credit_cnt[c] + 1'b1;
                    default: credit_cnt[c] <= credit_cnt[c];
                endcase
            end
        end
    end

endmodule

/* hw/crossbar.sv */
`timescale 1ns/10ps

`include "noc_settings.svh"

module crossbar (
    input  logic clk,
    input  logic rst_n,
    input  noc_pkg::flit_t [`NOC_NUM_PORTS*`NOC_NUM_VCS-1:0] head_flit,
    input  logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_PORTS*`NOC_NUM_VCS-1:0] grant,
    output logic [`NOC_NUM_PORTS-1:0] out_valid,
    output noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] out_flit
);
    import noc_pkg::*;

    localparam int NUM_FIFOS = `NOC_NUM_PORTS * `NOC_NUM_VCS;

    flit_t [`NOC_NUM_PORTS-1:0] sel_flit;
    logic [`NOC_NUM_PORTS-1:0] any_grant;

    // AND-OR mux since grant is one-hot per output
    always_comb begin
        sel_flit = '0;
        for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
            any_grant[o] = |grant[o];
            for (int i = 0; i < NUM_FIFOS; i++) begin
                sel_flit[o] = sel_flit[o] | (head_flit[i] & {$bits(flit_t){grant[o][i]}});
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else begin
            out_valid <= any_grant;
        end
    end

    // Flit register holds its last value while idle
    always_ff @(posedge clk) begin
        for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
            if (any_grant[o]) begin
                out_flit[o] <= sel_flit[o];
            end
        end
    end

endmodule

/* hw/noc_switch.sv */
`timescale 1ns/10ps

`include "noc_settings.svh"

module noc_switch #(
    parameter noc_pkg::node_id_t node = `NOC_NODE_ID
) (
    input  logic clk,
    input  logic rst_n,
    input  logic [`NOC_NUM_PORTS-1:0] in_valid,
    input  noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] in_flit,
    output noc_pkg::credit_t credit_out,
    output logic [`NOC_NUM_PORTS-1:0] out_valid,
    output noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] out_flit,
    input  noc_pkg::credit_t credit_in
);
    import noc_pkg::*;

    localparam int NUM_FIFOS = `NOC_NUM_PORTS * `NOC_NUM_VCS;

    credit_t head_valid;
    flit_t [NUM_FIFOS-1:0] head_flit;
    port_t [NUM_FIFOS-1:0] head_port;
    credit_t cfg_pop;
    logic [`NOC_NUM_PORTS-1:0][NUM_FIFOS-1:0] grant;
    credit_t pop;

    // A FIFO pops when claimed as config or granted by any output
    always_comb begin
        pop = cfg_pop;
        for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
            pop = pop | grant[o];
        end
    end

    vc_buffers vc_buffers_i (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .in_flit(in_flit),
        .pop(pop),
        .head_valid(head_valid),
        .head_flit(head_flit),
        .credit_out(credit_out)
    );

    route_compute #(
        .node(node)
    ) route_compute_i (
        .clk(clk),
        .rst_n(rst_n),
        .head_valid(head_valid),
        .head_flit(head_flit),
        .head_port(head_port),
        .cfg_pop(cfg_pop)
    );

    switch_allocator switch_allocator_i (
        .clk(clk),
        .rst_n(rst_n),
        .head_valid(head_valid),
        .head_port(head_port),
        .cfg_pop(cfg_pop),
        .credit_in(credit_in),
        .grant(grant)
    );

    crossbar crossbar_i (
        .clk(clk),
        .rst_n(rst_n),
        .head_flit(head_flit),
        .grant(grant),
        .out_valid(out_valid),
        .out_flit(out_flit)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period with reset low for the first 4 rising edges
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

/* verification/noc_switch_checker.sv */
`timescale 1ns/10ps

`include "noc_settings.svh"

module noc_switch_checker (
    input  logic clk,
    input  logic rst_n,
    input  logic [`NOC_NUM_PORTS-1:0] in_valid,
    input  noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] in_flit,
    input  noc_pkg::credit_t credit_out,
    input  logic [`NOC_NUM_PORTS-1:0] out_valid,
    input  noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] out_flit
);
    import noc_pkg::*;

    localparam int NUM_FIFOS = `NOC_NUM_PORTS * `NOC_NUM_VCS;

    port_t tbl [`NOC_TABLE_SIZE];
    flit_t exp_q [NUM_FIFOS][$];
    int accepted [NUM_FIFOS];
    int returned [NUM_FIFOS];
    int recv_cnt [NUM_FIFOS];
    int flit_errors = 0;
    int credit_errors = 0;

    always @(posedge clk) begin
        flit_t f;
        flit_t e;
        int c;
        if (!rst_n) begin
            for (int d = 0; d < `NOC_TABLE_SIZE; d++) begin
                tbl[d] = port_t'(d % `NOC_NUM_PORTS);
            end
        end else begin
            // Predict the destination queue of each accepted flit
            for (int p = 0; p < `NOC_NUM_PORTS; p++) begin
                if (in_valid[p]) begin
                    f = in_flit[p];
                    accepted[p + `NOC_NUM_PORTS * int'(f.vc)]++;
                    if (f.fmt == FMT_CFG && f.dest == node_id_t'(`NOC_NODE_ID)) begin
                        tbl[f.payload[6:2]] = f.payload[1:0];
                    end else begin
                        exp_q[int'(tbl[f.dest]) + `NOC_NUM_PORTS * int'(f.vc)].push_back(f);
                    end
                end
            end
            for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
                if (out_valid[o]) begin
                    c = o + `NOC_NUM_PORTS * int'(out_flit[o].vc);
                    recv_cnt[c]++;
                    if (exp_q[c].size() == 0) begin
                        flit_errors++;
                        $display("** Error @ %0t: unexpected flit %h on out %0d", $time,
                                 out_flit[o], o);
                    end else begin
                        e = exp_q[c].pop_front();
                        if (e != out_flit[o]) begin
                            flit_errors++;
                            $display("** Error @ %0t: out %0d got %h expected %h", $time,
                                     o, out_flit[o], e);
                        end
                    end
                end
            end
            for (int i = 0; i < NUM_FIFOS; i++) begin
                if (credit_out[i]) begin
                    returned[i]++;
                    if (returned[i] > accepted[i]) begin
                        credit_errors++;
                        $display("** Error @ %0t: extra credit_out on fifo %0d", $time, i);
                    end
                end
            end
        end
    end

    function automatic int pending();
        int n;
        n = 0;
        for (int c = 0; c < NUM_FIFOS; c++) begin
            n += exp_q[c].size();
        end
        return n;
    endfunction

    task automatic expect_count(input int c, input int n);
        if (recv_cnt[c] != n) begin
            flit_errors++;
            $display("** Error @ %0t: output vc %0d received %0d flits expected %0d",
                     $time, c, recv_cnt[c], n);
        end
    endtask

    task automatic final_check();
        for (int c = 0; c < NUM_FIFOS; c++) begin
            if (exp_q[c].size() != 0) begin
                flit_errors++;
                $display("** Error @ %0t: %0d flits never arrived on output vc %0d",
                         $time, exp_q[c].size(), c);
            end
            if (returned[c] != accepted[c]) begin
                credit_errors++;
                $display("** Error @ %0t: fifo %0d accepted %0d flits returned %0d credits",
                         $time, c, accepted[c], returned[c]);
            end
        end
    endtask

endmodule

/* verification/noc_switch_props.sv */
`timescale 1ns/10ps

`include "noc_settings.svh"

module noc_switch_props (
    input  logic clk,
    input  logic rst_n,
    input  logic [`NOC_NUM_PORTS-1:0] in_valid,
    input  noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] in_flit,
    input  noc_pkg::credit_t pop,
    input  logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_PORTS*`NOC_NUM_VCS-1:0] grant,
    input  noc_pkg::credit_t credit_in
);
    import noc_pkg::*;

    localparam int NUM_FIFOS = `NOC_NUM_PORTS * `NOC_NUM_VCS;

    int occ [NUM_FIFOS];
    int cred [NUM_FIFOS];
    credit_t push;
    credit_t sent;

    always_comb begin
        sent = '0;
        for (int i = 0; i < NUM_FIFOS; i++) begin
            push[i] = in_valid[i % `NOC_NUM_PORTS] &&
                      (in_flit[i % `NOC_NUM_PORTS].vc == vc_t'(i / `NOC_NUM_PORTS));
        end
        for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_FIFOS; i++) begin
                if (grant[o][i]) begin
                    sent[o + `NOC_NUM_PORTS * (i / `NOC_NUM_PORTS)] = 1'b1;
                end
            end
        end
    end

    // Shadow occupancy and downstream credit
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_FIFOS; i++) begin
                occ[i] <= 0;
                cred[i] <= `NOC_BUF_DEPTH;
            end
        end else begin
            for (int i = 0; i < NUM_FIFOS; i++) begin
                occ[i] <= occ[i] + ((push[i] && occ[i] < `NOC_BUF_DEPTH) ? 1 : 0)
                          - ((pop[i] && occ[i] != 0) ? 1 : 0);
                cred[i] <= cred[i] - (sent[i] ? 1 : 0) + (credit_in[i] ? 1 : 0);
            end
        end
    end

    for (genvar i = 0; i < NUM_FIFOS; i++) begin : g_fifo_props
        a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
            !(push[i] && occ[i] == `NOC_BUF_DEPTH))
            else $error("write to full fifo %0d", i);
        a_credit_held: assert property (@(posedge clk) disable iff (!rst_n)
            !(sent[i] && cred[i] == 0))
            else $error("send on output vc %0d without credit", i);
    end

    for (genvar o = 0; o < `NOC_NUM_PORTS; o++) begin : g_out_props
        a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(grant[o]))
            else $error("several grants on output %0d", o);
    end

endmodule

bind noc_switch noc_switch_props noc_switch_props_i (.*);

/* verification/noc_switch_tb.sv */
`timescale 1ns/10ps

`include "noc_settings.svh"

module noc_switch_tb;
    import noc_pkg::*;

    localparam int NUM_FIFOS = `NOC_NUM_PORTS * `NOC_NUM_VCS;
    localparam int WAIT_LIMIT = 1000;

    logic clk;
    logic rst_n;
    logic [`NOC_NUM_PORTS-1:0] in_valid;
    flit_t [`NOC_NUM_PORTS-1:0] in_flit;
    credit_t credit_out;
    logic [`NOC_NUM_PORTS-1:0] out_valid;
    flit_t [`NOC_NUM_PORTS-1:0] out_flit;
    credit_t credit_in;

    int cycle = 0;
    int sent_cnt [NUM_FIFOS];
    int ret_cnt [NUM_FIFOS];
    // Downstream model with credits due per slot, owed credits and a hold mask
    int due [4][NUM_FIFOS];
    int owed [NUM_FIFOS];
    credit_t hold;
    int tick = 0;

    tb_clock_gen tb_clock_gen_i (.clk(clk), .rst_n(rst_n));

    noc_switch noc_switch_i (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .in_flit(in_flit),
        .credit_out(credit_out),
        .out_valid(out_valid),
        .out_flit(out_flit),
        .credit_in(credit_in)
    );

    noc_switch_checker noc_switch_checker_i (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .in_flit(in_flit),
        .credit_out(credit_out),
        .out_valid(out_valid),
        .out_flit(out_flit)
    );

    always @(posedge clk) begin
        if (rst_n) begin
            cycle++;
            for (int i = 0; i < NUM_FIFOS; i++) begin
                ret_cnt[i] += int'(credit_out[i]);
            end
        end
    end

    // Each received flit returns its credit 1 to 3 cycles later
    always @(posedge clk) begin
        int c;
        for (int i = 0; i < NUM_FIFOS; i++) begin
            owed[i] += due[tick % 4][i];
            due[tick % 4][i] = 0;
        end
        for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
            if (rst_n && out_valid[o]) begin
                c = o + `NOC_NUM_PORTS * int'(out_flit[o].vc);
                due[(tick + 1 + int'($urandom % 3)) % 4][c]++;
            end
        end
        tick++;
        #10;
        for (int i = 0; i < NUM_FIFOS; i++) begin
            credit_in[i] = (owed[i] > 0) && !hold[i];
            if (credit_in[i]) begin
                owed[i]--;
            end
        end
    end

    task automatic finish_run(input bit timed_out);
        $display("Error counts: flit %0d, credit %0d, timeout %0d",
                 noc_switch_checker_i.flit_errors, noc_switch_checker_i.credit_errors,
                 int'(timed_out));
        if (!timed_out && noc_switch_checker_i.flit_errors == 0 &&
            noc_switch_checker_i.credit_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    function automatic bit has_credit(input int pv);
        return (`NOC_BUF_DEPTH - sent_cnt[pv] + ret_cnt[pv]) > 0;
    endfunction

    // Waits until the cycle is reached and, for a flit, an upstream credit
    task automatic wait_until(input int cyc, input int pv, input string what);
        int tmo;
        tmo = 0;
        while (cycle < cyc || (pv >= 0 && !has_credit(pv))) begin
            @(posedge clk);
            #10;
            tmo++;
            if (tmo > WAIT_LIMIT) begin
                $display("Timeout: testbench hung waiting for %s at cycle %0d", what, cyc);
                finish_run(1'b1);
            end
        end
    endtask

    task automatic send_flit(input int p, input flit_t f);
        in_flit[p] = f;
        in_valid[p] = 1'b1;
        sent_cnt[p + `NOC_NUM_PORTS * int'(f.vc)]++;
        @(posedge clk);
        #10;
        in_valid = '0;
    endtask

    initial begin
        int fd;
        int n;
        int tmo;
        int cyc;
        int a;
        int b;
        logic [7:0] op;
        logic [31:0] fmt_v;
        logic [31:0] dest_v;
        logic [31:0] vc_v;
        logic [31:0] pay_v;
        string line;
        flit_t f;
        in_valid = '0;
        in_flit = '0;
        credit_in = '0;
        hold = '0;
        void'($urandom(32'h374a_b84f));
        fd = $fopen("verification/noc_switch_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test data file");
            finish_run(1'b1);
        end
        tmo = 0;
        while (!rst_n) begin
            @(posedge clk);
            tmo++;
            if (tmo > 20) begin
                $display("Timeout: reset never released");
                finish_run(1'b1);
            end
        end
        #10;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %d %d %h %h %h %h", op, cyc, a, fmt_v, dest_v,
                            vc_v, pay_v);
                case (op)
                    "F": begin
                        f.fmt = fmt_t'(fmt_v);
                        f.dest = node_id_t'(dest_v);
                        f.vc = vc_t'(vc_v);
                        f.payload = pay_v[21:0];
                        wait_until(cyc, a + `NOC_NUM_PORTS * int'(f.vc), "upstream credit");
                        send_flit(a, f);
                    end
                    "H": begin
                        wait_until(cyc, -1, "hold cycle");
                        hold[a] = 1'b1;
                    end
                    "R": begin
                        wait_until(cyc, -1, "release cycle");
                        hold[a] = 1'b0;
                    end
                    "E": begin
                        b = int'(fmt_v);
                        wait_until(cyc, -1, "count check cycle");
                        noc_switch_checker_i.expect_count(a, b);
                    end
                    default: $display("Skipping unknown test data line: %s", line);
                endcase
            end
        end
        $fclose(fd);
        // Drain outputs and wait for all credits to come home
        tmo = 0;
        while ((noc_switch_checker_i.pending() != 0 || sent_cnt != ret_cnt) &&
               tmo <= WAIT_LIMIT) begin
            @(posedge clk);
            tmo++;
        end
        if (tmo > WAIT_LIMIT) begin
            $display("Timeout: flits or credits still outstanding at the end");
        end
        repeat (5) @(posedge clk);
        noc_switch_checker_i.final_check();
        finish_run(tmo > WAIT_LIMIT);
    end

endmodule

/* verification/noc_switch_testdata.txt */
# F cycle port fmt dest vc payload | H/R cycle out_vc | E cycle out_vc count
# out_vc = out_port + 4 * vc, all F fields after port in hex
F 2 0 0 01 0 000001
F 3 1 0 02 1 000002
F 4 2 0 04 0 000003
F 5 3 0 07 1 000004
F 6 0 0 0b 1 000005
F 7 1 0 05 0 000006
F 8 1 0 09 0 000007
F 9 1 0 0d 0 000008
F 12 2 1 03 0 000016
F 13 0 1 06 1 000123
F 20 3 0 05 1 000009
H 30 1
F 31 0 0 01 0 000a01
F 32 0 0 01 0 000a02
F 33 3 0 02 0 000b01
F 34 0 0 01 0 000a03
F 35 0 0 01 0 000a04
F 36 0 0 01 0 000a05
F 37 0 0 01 0 000a06
E 45 1 8
E 55 1 8
R 56 1
F 60 2 0 1f 1 000c01

/* vlog.f */
+incdir+hw
hw/noc_pkg.sv
hw/vc_buffers.sv
hw/route_compute.sv
hw/switch_allocator.sv
hw/crossbar.sv
hw/noc_switch.sv
verification/tb_clock_gen.sv
verification/noc_switch_checker.sv
verification/noc_switch_props.sv
verification/noc_switch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the switch testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module noc_switch_tb -o noc_switch_sim > build.log 2>&1 \
    && ./obj_dir/noc_switch_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "^RESULT: PASS$" sim.log 2>/dev/null && exit 0 || exit 1
